//--- Makefile
# Verilator build and run for the uart_top testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f uart_top.f --top-module uart_top_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vuart_top_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/uart_top_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top_checker (
    input logic clk,
    input logic rst_n,
    input logic tick,       // oversampling tick inside the DUT
    input logic tx,
    input logic tx_busy,
    input logic rx_read,
    input logic rx_valid,
    input logic rx_overrun
);

    int fail_cnt = 0; // failed assertions so far, read back by the testbench

    // ----------------------------------------
    // transmit line
    // ----------------------------------------
    tx_mark_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
    else begin
        $error("tx is low while tx_busy is low");
        fail_cnt++;
    end

    // line only moves on the clock right after a tick
    tx_moves_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
        (tx != $past(tx)) |-> $past(tick))
    else begin
        $error("tx changed without a preceding tick");
        fail_cnt++;
    end

    // ----------------------------------------
    // receive flags
    // ----------------------------------------
    rx_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rx_valid) |-> $past(rx_read))
    else begin
        $error("rx_valid fell without rx_read");
        fail_cnt++;
    end

    overrun_needs_word: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rx_overrun) |-> rx_valid)
    else begin
        $error("rx_overrun rose while rx_valid is low");
        fail_cnt++;
    end

endmodule

bind uart_top uart_top_checker chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .tick       (tick),
    .tx         (tx),
    .tx_busy    (tx_busy),
    .rx_read    (rx_read),
    .rx_valid   (rx_valid),
    .rx_overrun (rx_overrun)
);

`default_nettype wire

//--- dv/uart_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top_tb;

    import uart_line_pkg::*;

    localparam int BIT_CLKS      = OVERSAMPLE * CLKS_PER_TICK; // 64 clocks per bit
    localparam int FRAME_BITS    = DATA_BITS + 3;              // start, data, parity, stop
    localparam int FRAME_CLKS    = FRAME_BITS * BIT_CLKS;
    localparam int WAIT_CLKS     = 2 * FRAME_CLKS;             // per word timeout
    localparam int GLITCH_CLKS   = 4 * CLKS_PER_TICK;          // well short of MID_SAMPLE
    localparam int N_TESTS       = 12;
    localparam int WATCHDOG_CLKS = N_TESTS * 2 * FRAME_CLKS + 2000;

    typedef enum logic [1:0] {m_loop, m_inject, m_glitch, m_txdrop} mode_t;

    typedef struct {
        string          name;
        mode_t          mode;
        logic [7:0]     data;
        bit             bad_parity;
        bit             bad_stop;
        bit             read_after; // rx_read once the word is checked
    } entry_t;

    logic                 clk;
    logic                 rst_n;
    logic                 rx_drv;   // serial driver output
    logic                 loop_en;  // rx follows tx
    logic                 rx_line;
    logic                 tx;
    logic                 tx_write;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_full;
    logic                 tx_busy;
    logic                 rx_read;
    logic                 rx_valid;
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_parity_err;
    logic                 rx_frame_err;
    logic                 rx_overrun;

    entry_t     tests [N_TESTS];
    entry_t     cur;
    integer     seed;
    int         checks;
    int         mismatches;
    int         timeouts;
    int         asserts;
    bit         held;       // model of the rx buffer holding a word
    logic [7:0] h_data;
    bit         h_perr;
    bit         h_ferr;
    bit         exp_ovr;

    assign rx_line = loop_en ? tx : rx_drv;

    uart_top uart_top_i (
        .clk(clk), .rst_n(rst_n), .rx(rx_line), .tx(tx),
        .tx_write(tx_write), .tx_data(tx_data), .tx_full(tx_full), .tx_busy(tx_busy),
        .rx_read(rx_read), .rx_valid(rx_valid), .rx_data(rx_data),
        .rx_parity_err(rx_parity_err), .rx_frame_err(rx_frame_err), .rx_overrun(rx_overrun)
    );

    always #4 clk = ~clk; // 8 ns period

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic step();
        @(posedge clk);
        #1; // inputs move 1 ns after the edge
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [7:0] exp_v, input logic [7:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            mismatches++;
            $display("Mismatch in %s, %s: expected %02h, actual %02h", name, what, exp_v, act_v);
        end
    endtask

    task automatic write_byte(input logic [7:0] d);
        tx_data  = d;
        tx_write = 1'b1;
        step();
        tx_write = 1'b0;
    endtask

    // second write lands while tx_full is still high and must be lost
    task automatic write_and_drop(input string name, input logic [7:0] d);
        tx_data  = d;
        tx_write = 1'b1;
        step();
        check_val(name, "tx_full after write", 8'h01, 8'(tx_full));
        tx_data = ~d;
        step();
        tx_write = 1'b0;
        check_val(name, "tx_full after take", 8'h00, 8'(tx_full));
        check_val(name, "tx_busy after take", 8'h01, 8'(tx_busy));
    endtask

    task automatic send_frame(input logic [7:0] d, input bit bad_par, input bit bad_stop);
        logic [FRAME_BITS-1:0] bits; // bit 0 goes on the line first
        bits = {~bad_stop, (^d) ^ bad_par, d, 1'b0}; // even parity over the data
        for (int b = 0; b < FRAME_BITS; b++) begin
            rx_drv = bits[b];
            repeat (BIT_CLKS) step();
        end
        rx_drv = 1'b1;
        repeat (BIT_CLKS) step(); // one idle bit between frames
    endtask

    task automatic read_word();
        rx_read = 1'b1;
        step();
        rx_read = 1'b0;
    endtask

    task automatic wait_rx_event(input string name, input bit for_overrun);
        int n;
        n = 0;
        while (!(for_overrun ? rx_overrun : rx_valid) && n < WAIT_CLKS) begin
            step();
            n++;
        end
        if (!(for_overrun ? rx_overrun : rx_valid)) begin
            timeouts++;
            $display("%s: the receive side showed no word within %0d clocks", name, WAIT_CLKS);
        end
    endtask

    // ----------------------------------------
    // stimulus table and main sequence
    // ----------------------------------------
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        rx_drv     = 1'b1;
        loop_en    = 1'b0;
        tx_write   = 1'b0;
        tx_data    = '0;
        rx_read    = 1'b0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        held       = 1'b0;
        seed       = 44796;
        tests[0]  = '{"loop_55",      m_loop,   8'h55, 1'b0, 1'b0, 1'b1};
        tests[1]  = '{"loop_a3",      m_loop,   8'ha3, 1'b0, 1'b0, 1'b1};
        tests[2]  = '{"loop_rnd0",    m_loop,   8'($random(seed)), 1'b0, 1'b0, 1'b1};
        tests[3]  = '{"loop_rnd1",    m_loop,   8'($random(seed)), 1'b0, 1'b0, 1'b1};
        tests[4]  = '{"loop_rnd2",    m_loop,   8'($random(seed)), 1'b0, 1'b0, 1'b1};
        tests[5]  = '{"inj_rnd",      m_inject, 8'($random(seed)), 1'b0, 1'b0, 1'b1};
        tests[6]  = '{"inj_bad_par",  m_inject, 8'h3c, 1'b1, 1'b0, 1'b1};
        tests[7]  = '{"inj_bad_stop", m_inject, 8'hc5, 1'b0, 1'b1, 1'b1};
        tests[8]  = '{"glitch",       m_glitch, 8'h00, 1'b0, 1'b0, 1'b0};
        tests[9]  = '{"ovr_first",    m_inject, 8'h11, 1'b0, 1'b0, 1'b0}; // left unread
        tests[10] = '{"ovr_second",   m_inject, 8'h22, 1'b0, 1'b0, 1'b1};
        tests[11] = '{"tx_drop",      m_txdrop, 8'h5a, 1'b0, 1'b0, 1'b1};

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        check_val("reset", "tx", 8'h01, 8'(tx));
        check_val("reset", "tx_busy", 8'h00, 8'(tx_busy));
        check_val("reset", "tx_full", 8'h00, 8'(tx_full));
        check_val("reset", "rx_valid", 8'h00, 8'(rx_valid));
        check_val("reset", "rx_overrun", 8'h00, 8'(rx_overrun));

        for (int i = 0; i < N_TESTS; i++) begin
            cur = tests[i];
            while (tx_busy || tx_full) step(); // let the line go quiet first
            loop_en = (cur.mode == m_loop) || (cur.mode == m_txdrop);
            step();
            if (cur.mode == m_glitch) begin
                rx_drv = 1'b0;
                repeat (GLITCH_CLKS) step();
                rx_drv = 1'b1;
                repeat (FRAME_CLKS) step();
                check_val(cur.name, "rx_valid", 8'(held), 8'(rx_valid));
                check_val(cur.name, "rx_overrun", 8'h00, 8'(rx_overrun));
            end else begin
                exp_ovr = held; // a full buffer keeps the old word
                if (!held) begin
                    held   = 1'b1;
                    h_data = cur.data;
                    h_perr = cur.bad_parity;
                    h_ferr = cur.bad_stop;
                end
                case (cur.mode)
                    m_inject: send_frame(cur.data, cur.bad_parity, cur.bad_stop);
                    m_txdrop: write_and_drop(cur.name, cur.data);
                    default:  write_byte(cur.data);
                endcase
                wait_rx_event(cur.name, exp_ovr);
                check_val(cur.name, "rx_valid", 8'h01, 8'(rx_valid));
                check_val(cur.name, "rx_data", h_data, rx_data);
                check_val(cur.name, "rx_parity_err", 8'(h_perr), 8'(rx_parity_err));
                check_val(cur.name, "rx_frame_err", 8'(h_ferr), 8'(rx_frame_err));
                check_val(cur.name, "rx_overrun", 8'(exp_ovr), 8'(rx_overrun));
                if (cur.read_after) begin
                    read_word();
                    held = 1'b0;
                    check_val(cur.name, "rx_valid after read", 8'h00, 8'(rx_valid));
                    check_val(cur.name, "rx_overrun after read", 8'h00, 8'(rx_overrun));
                end
                if (cur.mode == m_txdrop) begin
                    repeat (WAIT_CLKS) step(); // dropped byte must never show up
                    check_val(cur.name, "rx_valid no second word", 8'h00, 8'(rx_valid));
                    check_val(cur.name, "tx_busy", 8'h00, 8'(tx_busy));
                end
            end
        end

        asserts = uart_top_i.chk_i.fail_cnt;
        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, mismatches, timeouts, asserts);
        if (mismatches == 0 && timeouts == 0 && asserts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("the run did not finish within %0d clocks and was stopped", WATCHDOG_CLKS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/uart_baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer (
    input  logic clk,
    input  logic rst_n,
    output logic tick  // one clock pulse per oversampling period
);

    import uart_line_pkg::*;

    logic [PRESCALE_W-1:0] div_cnt; // clocks since last tick
    logic                  wrap;

    assign wrap = (div_cnt == PRESCALE_W'(CLKS_PER_TICK - 1));

    // free running, no enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= wrap; // registered, so first tick lands CLKS_PER_TICK after reset
            if (wrap) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    // ----------------------------------------
    // frame format
    // ----------------------------------------
    localparam int DATA_BITS   = 8;    // data bits per frame, lsb first
    localparam bit parity_even = 1'b1; // even parity, clear for odd
    localparam bit LINE_IDLE   = 1'b1; // mark level, also the stop bit level

    // ----------------------------------------
    // line timing
    // ----------------------------------------
    localparam int OVERSAMPLE    = 16; // ticks per bit
    localparam int MID_SAMPLE    = 7;  // tick index inside a bit where rx samples
    localparam int CLKS_PER_TICK = 4;  // clocks per oversampling tick

    // counter widths derived from the above
    localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
    localparam int BIT_IDX_W  = $clog2(DATA_BITS);
    localparam int PRESCALE_W = $clog2(CLKS_PER_TICK);

    // position inside the frame, shared by both engines
    typedef enum logic [2:0] {
        st_idle,   // line at mark, nothing in flight
        st_start,  // start bit
        st_data,   // data bits
        st_parity, // parity bit
        st_stop    // stop bit
    } frame_state_t;

endpackage

`default_nettype wire

//--- hw/uart_reg_pkg.sv
`default_nettype none

package uart_reg_pkg;

    // host -> tx engine, one byte per write
    typedef logic [uart_line_pkg::DATA_BITS-1:0] tx_word_t;

    // ----------------------------------------
    // rx engine -> host
    // ----------------------------------------
    // the error bits travel with the byte so the host sees them
    // together with the data that caused them
    typedef struct packed {
        logic [uart_line_pkg::DATA_BITS-1:0] data; // received byte
        logic                                parity_err; // parity mismatch
        logic                                frame_err;  // stop bit sampled low
    } rx_word_t;

endpackage

`default_nettype wire

//--- hw/uart_rx_engine.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_engine (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          tick, // oversampling tick
    input  logic          rx,   // serial line in, asynchronous
    uart_word_if.producer dst
);

    import uart_line_pkg::*;
    import uart_reg_pkg::*;

    logic                  rx_meta;  // first sync stage
    logic                  rx_sync;  // line level in clk domain
    logic                  rx_prev;  // for edge detect
    logic                  fall;
    frame_state_t          state;
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic [BIT_IDX_W-1:0]  bit_idx;
    logic [DATA_BITS-1:0]  shreg;    // fills from the top, lsb first
    logic                  par;      // running parity of data samples
    logic                  perr;     // parity verdict of this frame
    logic                  put_q;
    rx_word_t              word_q;
    logic                  mid_hit;  // start bit centre
    logic                  samp_hit; // one full bit after the previous sample

    assign fall     = rx_prev && !rx_sync;
    assign mid_hit  = tick && (tick_cnt == TICK_CNT_W'(MID_SAMPLE));
    assign samp_hit = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

    assign dst.put      = put_q;
    assign dst.put_word = word_q;

    // ----------------------------------------
    // input synchronizer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= LINE_IDLE; // avoid a false start edge out of reset
            rx_sync <= LINE_IDLE;
            rx_prev <= LINE_IDLE;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ----------------------------------------
    // sampled data and the outgoing word
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if ((state == st_start) && mid_hit) begin
            par <= 1'b0;
        end else if ((state == st_data) && samp_hit) begin
            shreg <= {rx_sync, shreg[DATA_BITS-1:1]};
            par   <= par ^ rx_sync;
        end
        if ((state == st_parity) && samp_hit) begin
            perr <= par ^ rx_sync ^ ~parity_even; // 1 when the count is wrong
        end
        if ((state == st_stop) && samp_hit) begin
            word_q.data       <= shreg;
            word_q.parity_err <= perr;
            word_q.frame_err  <= !rx_sync; // stop must be mark
        end
    end

    // ----------------------------------------
    // frame sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            put_q    <= 1'b0;
        end else begin
            put_q <= 1'b0;
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (fall) begin
                        state    <= st_start;
                        tick_cnt <= '0; // count from the edge
                    end
                end
                st_start: begin
                    if (mid_hit) begin
                        tick_cnt <= '0; // later samples land on bit centres
                        bit_idx  <= '0;
                        // high at the centre is a glitch, drop it
                        state <= rx_sync ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (samp_hit) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
                            state <= st_parity;
                        end
                    end
                end
                st_parity: if (samp_hit) state <= st_stop;
                default: begin
                    // stop sample, hand the word over even with errors
                    if (samp_hit) begin
                        put_q <= 1'b1;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // serial line
    input  logic                                rx,
    output logic                                tx,
    // host transmit side
    input  logic                                tx_write,  // strobe
    input  uart_reg_pkg::tx_word_t              tx_data,
    output logic                                tx_full,   // write is dropped while set
    output logic                                tx_busy,
    // host receive side
    input  logic                                rx_read,   // strobe, frees the word
    output logic                                rx_valid,
    output logic [uart_line_pkg::DATA_BITS-1:0] rx_data,
    output logic                                rx_parity_err,
    output logic                                rx_frame_err,
    output logic                                rx_overrun // sticky until rx_read
);

    import uart_reg_pkg::*;

    logic tick;

    uart_word_if #(.T(tx_word_t)) tx_if ();
    uart_word_if #(.T(rx_word_t)) rx_if ();

    // ----------------------------------------
    // host side of the buffers
    // ----------------------------------------
    assign tx_if.put      = tx_write;
    assign tx_if.put_word = tx_data;
    assign tx_full        = tx_if.full;

    assign rx_if.take    = rx_read;
    assign rx_valid      = rx_if.full;
    assign rx_data       = rx_if.take_word.data;
    assign rx_parity_err = rx_if.take_word.parity_err;
    assign rx_frame_err  = rx_if.take_word.frame_err;

    uart_baud_timer baud_i (.clk(clk), .rst_n(rst_n), .tick(tick));

    // ----------------------------------------
    // transmit path
    // ----------------------------------------
    uart_word_buf #(.T(tx_word_t)) tx_buf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (tx_if.buffer),
        .overrun ()              // full write is simply dropped
    );

    uart_tx_engine tx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .src   (tx_if.consumer),
        .tx    (tx),
        .busy  (tx_busy)
    );

    // ----------------------------------------
    // receive path
    // ----------------------------------------
    uart_rx_engine rx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick),
        .rx    (rx),
        .dst   (rx_if.producer)
    );

    uart_word_buf #(.T(rx_word_t)) rx_buf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (rx_if.buffer),
        .overrun (rx_overrun)
    );

endmodule

`default_nettype wire

//--- hw/uart_tx_engine.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_engine (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          tick,   // oversampling tick
    uart_word_if.consumer src,
    output logic          tx,     // serial line out
    output logic          busy    // a frame is pending or on the line
);

    import uart_line_pkg::*;

    frame_state_t          state;
    logic [TICK_CNT_W-1:0] tick_cnt; // ticks spent in current bit
    logic [BIT_IDX_W-1:0]  bit_idx;  // data bit on the line
    logic [DATA_BITS-1:0]  shreg;    // bit 0 is the next data bit out
    logic                  par;      // running parity of bits sent
    logic                  line_lvl; // level owed to the line for this state
    logic                  bit_end;  // last tick of the current bit

    // grab the word as soon as we are free
    assign src.take = (state == st_idle) && src.full;
    assign busy     = (state != st_idle);
    assign bit_end  = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

    always_comb begin
        case (state)
            st_start:  line_lvl = 1'b0;
            st_data:   line_lvl = shreg[0];
            st_parity: line_lvl = par;
            default:   line_lvl = LINE_IDLE; // idle and stop
        endcase
    end

    // ----------------------------------------
    // shift register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (src.take) begin
            shreg <= src.take_word;
        end else if ((state == st_data) && bit_end) begin
            shreg <= shreg >> 1; // lsb first
        end
    end

    // ----------------------------------------
    // frame sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            par      <= 1'b0;
            tx       <= LINE_IDLE;
        end else begin
            // line only moves on a tick, so each bit gets exactly OVERSAMPLE ticks
            if (tick) begin
                tx <= line_lvl;
            end

            if (src.take) begin
                state    <= st_start; // start bit goes out on the next tick
                tick_cnt <= '0;
                bit_idx  <= '0;
                par      <= ~parity_even; // seed so odd parity needs no extra step
            end else if ((state != st_idle) && tick) begin
                tick_cnt <= tick_cnt + 1'b1;
                if (bit_end) begin
                    tick_cnt <= '0;
                    case (state)
                        st_start: state <= st_data;
                        st_data: begin
                            par     <= par ^ shreg[0];
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
                                state <= st_parity;
                            end
                        end
                        st_parity: state <= st_stop;
                        default:   state <= st_idle; // stop done, free for next word
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_word_buf.sv
`timescale 1ns/1ps
`default_nettype none

module uart_word_buf #(
    parameter type T = logic [7:0] // payload held by the buffer
) (
    input  logic          clk,
    input  logic          rst_n,
    uart_word_if.buffer   wr,
    output logic          overrun  // sticky, a put hit a full buffer
);

    T     word_q; // the single entry
    logic full_q;
    logic accept;

    // a put is only taken into an empty slot
    assign accept       = wr.put && !full_q;
    assign wr.full      = full_q;
    assign wr.take_word = word_q;

    // ----------------------------------------
    // payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= wr.put_word;
        end
    end

    // ----------------------------------------
    // flags
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_q  <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (accept) begin
                full_q <= 1'b1;
            end else if (wr.take) begin
                full_q <= 1'b0; // slot free the clock after take
            end

            // take acknowledges the error along with the word
            if (wr.take) begin
                overrun <= 1'b0;
            end else if (wr.put && full_q) begin
                overrun <= 1'b1; // new word is lost, old one kept
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/uart_word_if.sv
`timescale 1ns/1ps
`default_nettype none

// one word path: producer -> one-entry buffer -> consumer
interface uart_word_if #(
    parameter type T = logic [7:0] // payload carried on this path
);

    logic put;       // strobe, one clock
    T     put_word;  // valid with put
    logic full;      // level, buffer holds a word
    logic take;      // strobe, consumer grabs take_word
    T     take_word; // buffer contents, valid while full

    modport producer (output put, output put_word);

    modport buffer (
        input  put,
        input  put_word,
        input  take,
        output full,
        output take_word
    );

    modport consumer (input full, input take_word, output take);

endinterface

`default_nettype wire

//--- uart_top.f
hw/uart_line_pkg.sv
hw/uart_reg_pkg.sv
hw/uart_word_if.sv
hw/uart_baud_timer.sv
hw/uart_word_buf.sv
hw/uart_tx_engine.sv
hw/uart_rx_engine.sv
hw/uart_top.sv
dv/uart_top_checker.sv
dv/uart_top_tb.sv
